// File: build.f
hdl/ppu_pkg.sv
hdl/square_table.sv
hdl/board_locator.sv
hdl/pixel_compositor.sv
hdl/vga_timing.sv
hdl/ppu_top.sv
sim/tb_ppu.sv

// File: hdl/board_locator.sv
`timescale 1ns/1ps
`default_nettype none

module board_locator (
    input  wire logic                 vga_clk,
    input  wire logic                 rst_n,
    input  wire ppu_pkg::coord_t      next_x,
    input  wire ppu_pkg::coord_t      next_y,
    output logic                      in_board,
    output logic                      in_grid,
    output logic                      board_sel,
    output ppu_pkg::square_idx_t      sq_index,
    output logic [3:0]                off_x,
    output logic [3:0]                off_y,
    output logic                      in_title,
    output logic                      in_turn,
    output logic                      in_finish,
    output logic                      in_shore
);

    import ppu_pkg::*;

    logic        y_grid, y_box;
    logic        b0_grid, b1_grid;
    logic        b0_box, b1_box;
    logic [7:0]  dx, dy;
    square_idx_t row_base;
    square_idx_t sq_next;

    // vertical extent is shared by both boards
    assign y_grid = (next_y >= grid_y0) && (next_y < grid_y0 + grid_span);
    assign y_box  = (next_y >= grid_y0 - border_width) &&
                    (next_y < grid_y0 + grid_span + border_width);

    assign b0_grid = y_grid && (next_x >= grid_x0_b0) && (next_x < grid_x0_b0 + grid_span);
    assign b1_grid = y_grid && (next_x >= grid_x0_b1) && (next_x < grid_x0_b1 + grid_span);

    // border box is the grid grown on every side
    assign b0_box = y_box && (next_x >= grid_x0_b0 - border_width) &&
                    (next_x < grid_x0_b0 + grid_span + border_width);
    assign b1_box = y_box && (next_x >= grid_x0_b1 - border_width) &&
                    (next_x < grid_x0_b1 + grid_span + border_width);

    // offset into the grid, only the low byte matters
    assign dx = b1_grid ? 8'(next_x - grid_x0_b1) : 8'(next_x - grid_x0_b0);
    assign dy = 8'(next_y - grid_y0);

    // row * 10 + column
    assign row_base = {3'b000, dy[7:4]} * 7'd10;
    assign sq_next  = (b0_grid || b1_grid) ? row_base + {3'b000, dx[7:4]} : '0;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_board  <= 1'b0;
            in_grid   <= 1'b0;
            in_title  <= 1'b0;
            in_turn   <= 1'b0;
            in_finish <= 1'b0;
            in_shore  <= 1'b0;
        end else begin
            in_board  <= b0_box || b1_box;
            in_grid   <= b0_grid || b1_grid;
            in_title  <= (next_x >= title_x0) && (next_x < title_x1) &&
                         (next_y >= title_y0) && (next_y < title_y1);
            in_turn   <= (next_x >= turn_x0) && (next_x < turn_x1) &&
                         (next_y >= turn_y0) && (next_y < turn_y1);
            in_finish <= (next_x >= finish_x0) && (next_x < finish_x1) &&
                         (next_y >= finish_y0) && (next_y < finish_y1);
            in_shore  <= next_y >= shore_y0;
        end
    end

    // square address and offsets
    always_ff @(posedge vga_clk) begin
        board_sel <= b1_box;
        sq_index  <= sq_next;
        off_x     <= dx[3:0];
        off_y     <= dy[3:0];
    end

    a_grid_in_board: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        in_grid |-> in_board
    ) else $error("grid pixel outside board border");

endmodule

`default_nettype wire

// File: hdl/pixel_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
    input  wire logic                  vga_clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_board,
    input  wire logic                  in_grid,
    input  wire logic                  board_sel,
    input  wire ppu_pkg::square_idx_t  sq_index,
    input  wire logic [3:0]            off_x,
    input  wire logic [3:0]            off_y,
    input  wire logic                  in_title,
    input  wire logic                  in_turn,
    input  wire logic                  in_finish,
    input  wire logic                  in_shore,
    input  wire ppu_pkg::square_word_t rd_word,
    input  wire logic                  cur_turn,
    input  wire logic [1:0]            cur_finish,
    output logic                       rd_board,
    output ppu_pkg::square_idx_t       rd_index,
    output logic [7:0]                 pix_r,
    output logic [7:0]                 pix_g,
    output logic [7:0]                 pix_b
);

    import ppu_pkg::*;

    sq_state_t  st;
    ship_type_t stype;
    logic       sel_bit, ai_bit;
    logic       on_line;
    color332_t  state_col, marked_col, board_col, pix_col;

    // table lookup for the square under the current pixel
    assign rd_board = board_sel;
    assign rd_index = sq_index;

    assign st      = sq_state_t'(rd_word[5:4]);
    assign stype   = rd_word[3:2];
    assign sel_bit = rd_word[1];
    assign ai_bit  = rd_word[0];

    // first row and column of each square draws the grid line
    assign on_line = (off_x == 4'd0) || (off_y == 4'd0);

    always_comb begin
        case (st)
            sq_empty: state_col = col_empty;
            sq_miss:  state_col = board_sel ? col_miss_b1 : col_miss_b0;
            sq_hit:   state_col = board_sel ? col_hit_b1 : col_hit_b0;
            default:  state_col = col_ship[stype];
        endcase
    end

    // ai marking first, selection inverts whatever is left
    assign marked_col = sel_bit ? ~(ai_bit ? col_ai : state_col) :
                                   (ai_bit ? col_ai : state_col);

    assign board_col = !in_grid ? col_border :
                       on_line  ? col_grid   : marked_col;

    always_comb begin
        if (in_finish && cur_finish[1]) begin
            pix_col = cur_finish[0] ? col_win : col_lose;
        end else if (in_board) begin
            pix_col = board_col;
        end else if (in_shore) begin
            pix_col = col_shore;
        end else if (in_title) begin
            pix_col = col_title;
        end else if (in_turn) begin
            pix_col = cur_turn ? col_your_turn : col_waiting;
        end else begin
            pix_col = col_water;
        end
    end

    // RRRGGGBB to 8 bits per channel
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_r <= 8'h00;
            pix_g <= 8'h00;
            pix_b <= 8'h00;
        end else begin
            pix_r <= {pix_col[7:5], 5'b00000};
            pix_g <= {pix_col[4:2], 5'b00000};
            pix_b <= {pix_col[1:0], 6'b000000};
        end
    end

endmodule

`default_nettype wire

// File: hdl/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // pixel and square types
    typedef logic [9:0] coord_t;
    typedef logic [7:0] color332_t;
    typedef logic [6:0] square_idx_t;
    // ship lengths 2 to 5 as 0 to 3
    typedef logic [1:0] ship_type_t;
    // layout is {state[5:4], ship type[3:2], select[1], ai[0]}
    typedef logic [5:0] square_word_t;

    typedef enum logic [1:0] {
        sq_empty = 2'b00,
        sq_miss  = 2'b01,
        sq_hit   = 2'b10,
        sq_ship  = 2'b11
    } sq_state_t;

    // board geometry
    localparam coord_t square_size  = 10'd16;
    localparam coord_t grid_squares = 10'd10;
    localparam coord_t border_width = 10'd6;
    localparam coord_t grid_span    = grid_squares * square_size;
    localparam coord_t grid_x0_b0   = 10'd112;
    localparam coord_t grid_x0_b1   = 10'd390;
    localparam coord_t grid_y0      = 10'd199;
    localparam int unsigned square_count = 100;

    // scene bands, upper bounds exclusive
    localparam coord_t title_x0  = 10'd160;
    localparam coord_t title_x1  = 10'd481;
    localparam coord_t title_y0  = 10'd16;
    localparam coord_t title_y1  = 10'd80;
    localparam coord_t turn_x0   = 10'd170;
    localparam coord_t turn_x1   = 10'd470;
    localparam coord_t turn_y0   = 10'd94;
    localparam coord_t turn_y1   = 10'd130;
    localparam coord_t finish_x0 = 10'd180;
    localparam coord_t finish_x1 = 10'd460;
    localparam coord_t finish_y0 = 10'd170;
    localparam coord_t finish_y1 = 10'd310;
    localparam coord_t shore_y0  = 10'd416;

    // 640x480 at 60 Hz
    localparam coord_t h_active = 10'd640;
    localparam coord_t h_front  = 10'd16;
    localparam coord_t h_sync   = 10'd96;
    localparam coord_t h_total  = 10'd800;
    localparam coord_t v_active = 10'd480;
    localparam coord_t v_front  = 10'd10;
    localparam coord_t v_sync   = 10'd2;
    localparam coord_t v_total  = 10'd525;

    // flat scene colours
    localparam color332_t col_water     = 8'h0B;
    localparam color332_t col_shore     = 8'hD4;
    localparam color332_t col_title     = 8'hFC;
    localparam color332_t col_your_turn = 8'h1C;
    localparam color332_t col_waiting   = 8'h92;
    localparam color332_t col_win       = 8'h1F;
    localparam color332_t col_lose      = 8'hE0;

    // board colours
    localparam color332_t col_border  = 8'h05;
    localparam color332_t col_grid    = 8'h00;
    localparam color332_t col_empty   = 8'h17;
    localparam color332_t col_miss_b0 = 8'hDB;
    localparam color332_t col_miss_b1 = 8'hB6;
    localparam color332_t col_hit_b0  = 8'hE4;
    localparam color332_t col_hit_b1  = 8'hC0;
    // indexed by ship type
    localparam color332_t col_ship [4] = '{8'h6D, 8'h49, 8'h92, 8'h25};
    localparam color332_t col_ai      = 8'h1C;

endpackage

`default_nettype wire

// File: hdl/ppu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
    input  wire logic                 vga_clk,
    input  wire logic                 rst_n,
    input  wire logic                 receive,
    input  wire logic                 board,
    input  wire ppu_pkg::square_idx_t square_update,
    input  wire ppu_pkg::sq_state_t   square_state,
    input  wire ppu_pkg::ship_type_t  ship_type,
    input  wire logic                 square_sel,
    input  wire logic                 ai,
    input  wire logic [1:0]           turn,
    input  wire logic [1:0]           finish,
    output logic [7:0]                red,
    output logic [7:0]                green,
    output logic [7:0]                blue,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      blank_n
);

    import ppu_pkg::*;

    coord_t       next_x, next_y;
    logic         in_board, in_grid, board_sel;
    square_idx_t  sq_index, rd_index;
    logic [3:0]   off_x, off_y;
    logic         in_title, in_turn, in_finish, in_shore;
    logic         rd_board;
    square_word_t rd_word;
    logic         cur_turn;
    logic [1:0]   cur_finish;
    logic [7:0]   pix_r, pix_g, pix_b;

    square_table u_square_table (
        .vga_clk, .rst_n, .receive, .board, .square_update, .square_state,
        .ship_type, .square_sel, .ai, .turn, .finish,
        .rd_board, .rd_index, .rd_word, .cur_turn, .cur_finish
    );

    board_locator u_board_locator (
        .vga_clk, .rst_n, .next_x, .next_y,
        .in_board, .in_grid, .board_sel, .sq_index, .off_x, .off_y,
        .in_title, .in_turn, .in_finish, .in_shore
    );

    pixel_compositor u_pixel_compositor (
        .vga_clk, .rst_n,
        .in_board, .in_grid, .board_sel, .sq_index, .off_x, .off_y,
        .in_title, .in_turn, .in_finish, .in_shore,
        .rd_word, .cur_turn, .cur_finish,
        .rd_board, .rd_index, .pix_r, .pix_g, .pix_b
    );

    vga_timing u_vga_timing (
        .vga_clk, .rst_n, .pix_r, .pix_g, .pix_b,
        .next_x, .next_y, .red, .green, .blue, .hsync, .vsync, .blank_n
    );

endmodule

`default_nettype wire

// File: hdl/square_table.sv
`timescale 1ns/1ps
`default_nettype none

module square_table (
    input  wire logic                 vga_clk,
    input  wire logic                 rst_n,
    input  wire logic                 receive,
    input  wire logic                 board,
    input  wire ppu_pkg::square_idx_t square_update,
    input  wire ppu_pkg::sq_state_t   square_state,
    input  wire ppu_pkg::ship_type_t  ship_type,
    input  wire logic                 square_sel,
    input  wire logic                 ai,
    input  wire logic [1:0]           turn,
    input  wire logic [1:0]           finish,
    input  wire logic                 rd_board,
    input  wire ppu_pkg::square_idx_t rd_index,
    output ppu_pkg::square_word_t     rd_word,
    output logic                      cur_turn,
    output logic [1:0]                cur_finish
);

    import ppu_pkg::*;

    // one word per square, board 0 then board 1
    square_word_t sq_mem [2][square_count];

    logic sq_write;

    // turn beats finish beats square write
    assign sq_write = receive && !turn[1] && !finish[1];

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_mem     <= '{default: '0};
            cur_turn   <= 1'b0;
            cur_finish <= 2'b00;
        end else if (receive) begin
            if (turn[1]) begin
                cur_turn <= turn[0];
            end else if (finish[1]) begin
                cur_finish <= finish;
            end else begin
                sq_mem[board][square_update] <= {square_state, ship_type, square_sel, ai};
            end
        end
    end

    // compositor only addresses squares inside a grid
    assign rd_word = sq_mem[rd_board][rd_index];

    // controller must never address past the last square
    a_square_in_range: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        sq_write |-> (int'(square_update) < square_count)
    ) else $error("square_update %0d out of range", square_update);

endmodule

`default_nettype wire

// File: hdl/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire logic            vga_clk,
    input  wire logic            rst_n,
    input  wire logic [7:0]      pix_r,
    input  wire logic [7:0]      pix_g,
    input  wire logic [7:0]      pix_b,
    output ppu_pkg::coord_t      next_x,
    output ppu_pkg::coord_t      next_y,
    output logic [7:0]           red,
    output logic [7:0]           green,
    output logic [7:0]           blue,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 blank_n
);

    import ppu_pkg::*;

    coord_t     h_cnt, v_cnt;
    logic       active, hs, vs;
    // three stages to line up with the colour pipeline
    logic [2:0] act_d, hs_d, vs_d;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_total - 1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == v_total - 1) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign next_x = h_cnt;
    assign next_y = v_cnt;

    assign active = (h_cnt < h_active) && (v_cnt < v_active);
    // sync pulses are active low
    assign hs = !((h_cnt >= h_active + h_front) && (h_cnt < h_active + h_front + h_sync));
    assign vs = !((v_cnt >= v_active + v_front) && (v_cnt < v_active + v_front + v_sync));

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            act_d <= 3'b000;
            hs_d  <= 3'b111;
            vs_d  <= 3'b111;
            red   <= 8'h00;
            green <= 8'h00;
            blue  <= 8'h00;
        end else begin
            act_d <= {act_d[1:0], active};
            hs_d  <= {hs_d[1:0], hs};
            vs_d  <= {vs_d[1:0], vs};
            // pixel from the compositor belongs to stage two
            red   <= act_d[1] ? pix_r : 8'h00;
            green <= act_d[1] ? pix_g : 8'h00;
            blue  <= act_d[1] ? pix_b : 8'h00;
        end
    end

    assign blank_n = act_d[2];
    assign hsync   = hs_d[2];
    assign vsync   = vs_d[2];

    a_no_active_in_vsync: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        blank_n |-> vsync
    ) else $error("active video during vsync pulse");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_ppu -f build.f
./obj_dir/Vtb_ppu > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi

// File: sim/ppu_vectors.txt
# U board index state type sel ai turn finish  (state 0 empty 1 miss 2 hit 3 ship)
# E ends a frame's updates; P x y colour, with colour as RRRGGGBB hex
E
P 10 10 0B
P 320 450 D4
P 160 16 FC
P 469 129 92
P 106 193 05
P 555 364 05
P 112 205 00
P 271 358 17
P 391 200 17
U 0 0 1 3 0 0 00 00
U 0 12 2 0 0 0 00 00
U 0 34 3 0 0 0 00 00
U 0 55 3 1 0 0 00 00
U 0 78 3 2 0 0 00 00
U 0 99 3 3 0 0 00 00
U 1 0 1 0 0 0 00 00
U 1 9 2 0 0 0 00 00
E
P 120 207 DB
P 152 223 E4
P 184 255 6D
P 200 287 49
P 248 319 92
P 264 351 25
P 398 207 B6
P 542 207 C0
P 136 207 17
U 0 22 0 0 0 1 00 00
U 0 23 2 0 1 0 00 00
U 1 23 3 1 1 1 00 00
U 1 24 1 0 1 0 00 00
E
P 152 239 1C
P 144 231 00
P 168 239 1B
P 446 239 E3
P 462 239 49
U 0 0 2 0 1 1 11 11
E
P 120 207 DB
P 320 100 1C
P 320 180 0B
U 0 0 0 0 0 0 10 11
U 0 0 0 0 0 0 00 11
E
P 320 110 92
P 200 250 1F
P 179 250 6D
U 0 0 0 0 0 0 00 10
E
P 200 250 E0
P 320 180 E0

// File: sim/tb_ppu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppu;

    import ppu_pkg::*;

    // one full 800x525 raster at 40 ns per pixel
    localparam longint frame_ns = longint'(h_total) * longint'(v_total) * 40;

    logic        vga_clk;
    logic        rst_n;
    logic        receive;
    logic        board;
    square_idx_t square_update;
    sq_state_t   square_state;
    ship_type_t  ship_type;
    logic        square_sel;
    logic        ai;
    logic [1:0]  turn;
    logic [1:0]  finish;
    logic [7:0]  red, green, blue;
    logic        hsync, vsync, blank_n;

    // update word is {board, index, state, type, sel, ai, turn, finish}
    logic [17:0] upd_word [$];
    int          upd_frame [$];
    int          prb_frame [$];
    int          prb_x [$];
    int          prb_y [$];
    int          prb_line [$];
    logic [7:0]  prb_col [$];
    int          num_frames;
    int          probes_checked;
    logic        vectors_loaded;

    ppu_top DUT (
        .vga_clk, .rst_n, .receive, .board, .square_update, .square_state,
        .ship_type, .square_sel, .ai, .turn, .finish,
        .red, .green, .blue, .hsync, .vsync, .blank_n
    );

    always #20 vga_clk = ~vga_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
        if (actual !== expected)
            abort_run($sformatf("ERR %s expected %06h actual %06h", name, expected, actual));
    endtask

    // RRRGGGBB widened to three 8-bit channels, low bits zero
    function automatic logic [23:0] rgb_from_332(input logic [7:0] c);
        return {c[7:5], 5'd0, c[4:2], 5'd0, c[1:0], 6'd0};
    endfunction

    task automatic load_vectors();
        int    fd;
        int    lineno;
        int    frame;
        int    n;
        int    f [8];
        logic  in_probes;
        byte   tag;
        string text;
        string rest;
        fd = $fopen("sim/ppu_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open sim/ppu_vectors.txt");
        lineno = 0;
        frame = 0;
        in_probes = 1'b0;
        while ($fgets(text, fd) != 0) begin
            lineno++;
            tag = text.getc(0);
            rest = text.substr(1, text.len() - 1);
            if (text.len() < 2 || tag == "#") begin
                continue;
            end else if (tag == "U") begin
                // an update after probes opens the next frame
                if (in_probes)
                    frame++;
                in_probes = 1'b0;
                n = $sscanf(rest, "%d %d %d %d %d %d %b %b",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n != 8)
                    abort_run($sformatf("malformed update on vector line %0d", lineno));
                upd_frame.push_back(frame);
                upd_word.push_back({1'(f[0]), 7'(f[1]), 2'(f[2]), 2'(f[3]),
                                    1'(f[4]), 1'(f[5]), 2'(f[6]), 2'(f[7])});
            end else if (tag == "E") begin
                if (in_probes)
                    frame++;
                in_probes = 1'b1;
            end else if (tag == "P") begin
                n = $sscanf(rest, "%d %d %h", f[0], f[1], f[2]);
                if (n != 3 || !in_probes)
                    abort_run($sformatf("malformed probe on vector line %0d", lineno));
                prb_frame.push_back(frame);
                prb_x.push_back(f[0]);
                prb_y.push_back(f[1]);
                prb_col.push_back(8'(f[2]));
                prb_line.push_back(lineno);
            end else begin
                abort_run($sformatf("unknown record on vector line %0d", lineno));
            end
        end
        $fclose(fd);
        num_frames = in_probes ? frame + 1 : frame;
    endtask

    task automatic drive_updates(input int fr);
        logic [17:0] w;
        logic        sent;
        sent = 1'b0;
        foreach (upd_word[i]) begin
            if (upd_frame[i] == fr) begin
                w = upd_word[i];
                @(negedge vga_clk);
                receive       = 1'b1;
                board         = w[17];
                square_update = w[16:10];
                square_state  = sq_state_t'(w[9:8]);
                ship_type     = w[7:6];
                square_sel    = w[5];
                ai            = w[4];
                turn          = w[3:2];
                finish        = w[1:0];
                sent          = 1'b1;
            end
        end
        if (sent) begin
            @(negedge vga_clk);
            receive = 1'b0;
        end
    endtask

    // walks the active area from blank_n and checks every probe of one frame
    task automatic capture_frame(input int fr);
        int   sel [$];
        logic done [$];
        int   found;
        int   pix_row;
        int   pix_col;
        int   blank_cnt;
        int   k;
        logic line_active;
        logic exp_hsync;
        foreach (prb_frame[i]) begin
            if (prb_frame[i] == fr) begin
                sel.push_back(i);
                done.push_back(1'b0);
            end
        end
        found = 0;
        pix_row = 0;
        pix_col = 0;
        blank_cnt = 0;
        line_active = 1'b0;
        while (found < sel.size()) begin
            @(negedge vga_clk);
            if (blank_n) begin
                foreach (sel[j]) begin
                    k = sel[j];
                    if (!done[j] && prb_x[k] == pix_col && prb_y[k] == pix_row) begin
                        check_value($sformatf("vec_line%0d_x%0d_y%0d", prb_line[k],
                                              prb_x[k], prb_y[k]),
                                    rgb_from_332(prb_col[k]), {red, green, blue});
                        done[j] = 1'b1;
                        found++;
                        probes_checked++;
                    end
                end
                pix_col++;
                blank_cnt = 0;
                line_active = 1'b1;
            end else begin
                check_value("blanking", 24'h000000, {red, green, blue});
                // sync pulse sits after the front porch of each active line
                if (pix_row > 0 || line_active) begin
                    exp_hsync = !(blank_cnt >= int'(h_front) &&
                                  blank_cnt < int'(h_front + h_sync));
                    check_value($sformatf("hsync_line%0d_blank%0d", pix_row, blank_cnt),
                                {23'd0, exp_hsync}, {23'd0, hsync});
                end
                blank_cnt++;
                if (line_active) begin
                    pix_row++;
                    pix_col = 0;
                    line_active = 1'b0;
                    if (pix_row >= int'(v_active) && found < sel.size())
                        abort_run($sformatf("frame %0d ended before all probes", fr));
                end
            end
        end
    endtask

    initial begin
        vga_clk        = 1'b0;
        rst_n          = 1'b0;
        receive        = 1'b0;
        board          = 1'b0;
        square_update  = '0;
        square_state   = sq_empty;
        ship_type      = '0;
        square_sel     = 1'b0;
        ai             = 1'b0;
        turn           = 2'b00;
        finish         = 2'b00;
        probes_checked = 0;
        vectors_loaded = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (10) @(negedge vga_clk);
        // syncs idle high, blank_n low, colours dark in reset
        check_value("reset_sync", 24'h000006, {21'd0, hsync, vsync, blank_n});
        check_value("reset_colour", 24'h000000, {red, green, blue});
        rst_n = 1'b1;
        for (int fr = 0; fr < num_frames; fr++) begin
            drive_updates(fr);
            @(negedge vsync);
            capture_frame(fr);
        end
        if (probes_checked == prb_x.size()) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("some probes were never checked");
        end
    end

    initial begin
        wait (vectors_loaded);
        #(longint'(num_frames + 2) * frame_ns);
        abort_run($sformatf("watchdog expired after %0d frame times", num_frames + 2));
    end

endmodule

`default_nettype wire
